// File: Bender.yml
package:
  name: tetris_core

sources:
  - hw/tetris_pkg.sv
  - hw/menu_ctrl.sv
  - hw/title_screen.sv
  - hw/tetris_well.sv
  - hw/tetris_top.sv
  - target: simulation
    files:
      - sim/tb_tetris.sv

// File: all.f
hw/tetris_pkg.sv
hw/menu_ctrl.sv
hw/title_screen.sv
hw/tetris_well.sv
hw/tetris_top.sv
sim/tb_tetris.sv

// File: hw/menu_ctrl.sv
`timescale 1ns/100ps

module menu_ctrl
    import tetris_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [7:0]  i_key,
    input  logic        i_key_valid,
    input  logic        i_over_1,
    input  logic        i_over_2,
    output menu_state_t o_state,
    output logic        o_mode,
    output logic        o_start,
    output logic        o_stop
);

    logic [7:0]  key_q;
    logic        key_v_q;
    logic        over_1_q;
    logic        over_2_q;
    logic        over_rise;
    menu_state_t state_n;
    logic        mode_n;
    logic        start_n;
    logic        stop_n;

    assign over_rise = (i_over_1 && !over_1_q) || (i_over_2 && !over_2_q);

    always_comb begin
        state_n = o_state;
        mode_n  = o_mode;
        start_n = 1'b0;
        stop_n  = 1'b0;
        case (o_state)
            MENU_IDLE: begin
                if (key_v_q) begin
                    case (key_q)
                        KEY_UP:   mode_n = 1'b0;
                        KEY_DOWN: mode_n = 1'b1;
                        KEY_ENTER: begin
                            state_n = o_mode ? MENU_2P : MENU_1P;
                            start_n = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            MENU_1P: begin
                if (key_v_q && key_q == KEY_ESC) begin
                    state_n = MENU_IDLE;
                    stop_n  = 1'b1;
                end
            end
            MENU_2P: begin
                if (key_v_q && key_q == KEY_ESC) begin
                    state_n = MENU_IDLE;
                    stop_n  = 1'b1;
                end else if (over_rise) begin
                    // round ends but the screen stays on both wells
                    stop_n = 1'b1;
                end
            end
            default: state_n = MENU_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            key_q    <= 8'd0;
            key_v_q  <= 1'b0;
            over_1_q <= 1'b0;
            over_2_q <= 1'b0;
            o_state  <= MENU_IDLE;
            o_mode   <= 1'b0;
            o_start  <= 1'b0;
            o_stop   <= 1'b0;
        end else begin
            key_q    <= i_key;
            key_v_q  <= i_key_valid;
            over_1_q <= i_over_1;
            over_2_q <= i_over_2;
            o_state  <= state_n;
            o_mode   <= mode_n;
            o_start  <= start_n;
            o_stop   <= stop_n;
        end
    end

    a_start_stop_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_start && o_stop));

endmodule

// File: hw/tetris_pkg.sv
package tetris_pkg;

    // keyboard scan codes as delivered by the external decoder
    typedef enum logic [7:0] {
        KEY_UP    = 8'h75,
        KEY_DOWN  = 8'h72,
        KEY_LEFT  = 8'h6B,
        KEY_RIGHT = 8'h74,
        KEY_ENTER = 8'h5A,
        KEY_ESC   = 8'h76
    } key_code_t;

    typedef enum logic [1:0] {
        MENU_IDLE = 2'd0,
        MENU_1P   = 2'd1,
        MENU_2P   = 2'd2
    } menu_state_t;

    // grey background level on r, g and b
    localparam logic [7:0] COLOR_BG = 8'd50;
    localparam logic [7:0] COLOR_TEXT = 8'd255;

    // locked cell colour
    localparam logic [7:0] LOCK_R = 8'd0;
    localparam logic [7:0] LOCK_G = 8'd200;
    localparam logic [7:0] LOCK_B = 8'd255;

    // falling cell colour
    localparam logic [7:0] FALL_R = 8'd255;
    localparam logic [7:0] FALL_G = 8'd160;
    localparam logic [7:0] FALL_B = 8'd0;

    // grid size in cells
    localparam int WELL_W = 10;
    localparam int WELL_H = 20;

    // power of two cell edge in pixels
    localparam int CELL_PX = 16;

    // well placement on the 640x480 raster
    localparam int WIN_1P_X = 240;
    localparam int WIN_2P_X_A = 80;
    localparam int WIN_2P_X_B = 400;
    localparam int WIN_Y = 80;

    localparam int WIN_W = WELL_W * CELL_PX;
    localparam int WIN_H = WELL_H * CELL_PX;

endpackage

// File: hw/tetris_top.sv
`timescale 1ns/100ps

module tetris_top
    import tetris_pkg::*;
#(
    parameter key_code_t MOVE_LEFT  = KEY_LEFT,
    parameter key_code_t MOVE_RIGHT = KEY_RIGHT
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [9:0]  i_x,
    input  logic [9:0]  i_y,
    input  logic [7:0]  i_key_1,
    input  logic        i_key_1_valid,
    input  logic [7:0]  i_key_2,
    input  logic        i_key_2_valid,
    input  logic        i_drop,
    output menu_state_t o_menu_state,
    output logic [7:0]  o_lines_1,
    output logic [7:0]  o_lines_2,
    output logic        o_over_1,
    output logic        o_over_2,
    output logic [7:0]  o_vga_r,
    output logic [7:0]  o_vga_g,
    output logic [7:0]  o_vga_b
);

    logic        mode, start, stop;
    logic [9:0]  base_1, dx_1, dx_2, dy;
    logic        in_y, in_win_1, in_win_2;
    logic        win_1_q, win_2_q;
    menu_state_t state_q;
    logic [7:0]  t_r, t_g, t_b;
    logic [7:0]  r_1, g_1, b_1;
    logic [7:0]  r_2, g_2, b_2;

    menu_ctrl u_menu (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_key(i_key_1), .i_key_valid(i_key_1_valid),
        .i_over_1(o_over_1), .i_over_2(o_over_2),
        .o_state(o_menu_state), .o_mode(mode), .o_start(start), .o_stop(stop)
    );

    title_screen u_title (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_x(i_x), .i_y(i_y), .i_mode(mode),
        .o_r(t_r), .o_g(t_g), .o_b(t_b)
    );

    // player one's window moves left when the second well is on screen
    assign base_1 = (o_menu_state == MENU_2P) ? 10'(WIN_2P_X_A) : 10'(WIN_1P_X);
    assign dx_1 = i_x - base_1;
    assign dx_2 = i_x - 10'(WIN_2P_X_B);
    assign dy = i_y - 10'(WIN_Y);
    assign in_y = (i_y >= WIN_Y) && (i_y < WIN_Y + WIN_H);
    assign in_win_1 = (o_menu_state != MENU_IDLE) && in_y &&
                      (i_x >= base_1) && (i_x < base_1 + 10'(WIN_W));
    assign in_win_2 = (o_menu_state == MENU_2P) && in_y &&
                      (i_x >= WIN_2P_X_B) && (i_x < WIN_2P_X_B + WIN_W);

    tetris_well #(.KEY_LEFT_CODE(MOVE_LEFT), .KEY_RIGHT_CODE(MOVE_RIGHT)) u_well_1 (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(start), .i_stop(stop),
        .i_key(i_key_1), .i_key_valid(i_key_1_valid), .i_drop(i_drop),
        .i_cx(dx_1[7:0]), .i_cy(dy[8:0]), .i_in_win(in_win_1),
        .o_lines(o_lines_1), .o_over(o_over_1), .o_r(r_1), .o_g(g_1), .o_b(b_1)
    );

    // second well only plays in a two-player round
    tetris_well #(.KEY_LEFT_CODE(MOVE_LEFT), .KEY_RIGHT_CODE(MOVE_RIGHT)) u_well_2 (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_start(start && o_menu_state == MENU_2P), .i_stop(stop),
        .i_key(i_key_2), .i_key_valid(i_key_2_valid), .i_drop(i_drop),
        .i_cx(dx_2[7:0]), .i_cy(dy[8:0]), .i_in_win(in_win_2),
        .o_lines(o_lines_2), .o_over(o_over_2), .o_r(r_2), .o_g(g_2), .o_b(b_2)
    );

    // line up with the registered colours
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            win_1_q <= 1'b0;
            win_2_q <= 1'b0;
            state_q <= MENU_IDLE;
        end else begin
            win_1_q <= in_win_1;
            win_2_q <= in_win_2;
            state_q <= o_menu_state;
        end
    end

    always_comb begin
        {o_vga_r, o_vga_g, o_vga_b} = {COLOR_BG, COLOR_BG, COLOR_BG};
        if (state_q == MENU_IDLE) begin
            {o_vga_r, o_vga_g, o_vga_b} = {t_r, t_g, t_b};
        end else if (win_1_q) begin
            {o_vga_r, o_vga_g, o_vga_b} = {r_1, g_1, b_1};
        end else if (state_q == MENU_2P && win_2_q) begin
            {o_vga_r, o_vga_g, o_vga_b} = {r_2, g_2, b_2};
        end
    end

endmodule

// File: hw/tetris_well.sv
`timescale 1ns/100ps

module tetris_well
    import tetris_pkg::*;
#(
    parameter key_code_t KEY_LEFT_CODE  = KEY_LEFT,
    parameter key_code_t KEY_RIGHT_CODE = KEY_RIGHT
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_stop,
    input  logic [7:0] i_key,
    input  logic       i_key_valid,
    input  logic       i_drop,
    input  logic [7:0] i_cx,
    input  logic [8:0] i_cy,
    input  logic       i_in_win,
    output logic [7:0] o_lines,
    output logic       o_over,
    output logic [7:0] o_r,
    output logic [7:0] o_g,
    output logic [7:0] o_b
);

    localparam int COL_W = $clog2(WELL_W);
    localparam int ROW_W = $clog2(WELL_H);
    localparam int CELL_SH = $clog2(CELL_PX);
    localparam logic [COL_W-1:0] SPAWN_COL = COL_W'(4);

    typedef enum logic [1:0] {
        W_IDLE,
        W_PLAY,
        W_FROZEN,
        W_OVER
    } well_state_t;

    well_state_t       st, st_n;
    logic [WELL_W-1:0] grid   [WELL_H];
    logic [WELL_W-1:0] grid_n [WELL_H];
    logic [COL_W-1:0]  col, col_n;
    logic [ROW_W-1:0]  row, row_n;
    logic [7:0]        lines_n;
    logic              over_n;
    logic              drop_q;
    logic              blocked;
    logic [COL_W-1:0]  pix_col;
    logic [ROW_W-1:0]  pix_row;
    logic [7:0]        pix_r, pix_g, pix_b;

    // drop acts one edge after its strobe and so lands after a move in the same cycle
    always_comb begin
        st_n    = st;
        grid_n  = grid;
        col_n   = col;
        row_n   = row;
        lines_n = o_lines;
        over_n  = o_over;
        blocked = 1'b0;
        if (i_start) begin
            grid_n  = '{default: '0};
            col_n   = SPAWN_COL;
            row_n   = '0;
            lines_n = 8'd0;
            over_n  = 1'b0;
            st_n    = W_PLAY;
        end else if (i_stop) begin
            if (st == W_PLAY) begin
                st_n = W_FROZEN;
            end
        end else if (st == W_PLAY) begin
            if (i_key_valid && i_key == KEY_LEFT_CODE && col != '0 &&
                !grid[row][col - 1'b1]) begin
                col_n = col - 1'b1;
            end else if (i_key_valid && i_key == KEY_RIGHT_CODE && col != WELL_W - 1 &&
                         !grid[row][col + 1'b1]) begin
                col_n = col + 1'b1;
            end
            if (drop_q) begin
                blocked = (row == WELL_H - 1) ? 1'b1 : grid[row + 1'b1][col_n];
                if (blocked) begin
                    grid_n[row][col_n] = 1'b1;
                    if (&grid_n[row]) begin
                        // full row goes and everything above slides down one
                        for (int r = 1; r < WELL_H; r++) begin
                            if (r <= row) begin
                                grid_n[r] = grid[r-1];
                            end
                        end
                        grid_n[0] = '0;
                        lines_n = o_lines + 8'd1;
                    end
                    col_n = SPAWN_COL;
                    row_n = '0;
                    if (grid_n[0][SPAWN_COL]) begin
                        over_n = 1'b1;
                        st_n   = W_OVER;
                    end
                end else begin
                    row_n = row + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st      <= W_IDLE;
            grid    <= '{default: '0};
            col     <= SPAWN_COL;
            row     <= '0;
            o_lines <= 8'd0;
            o_over  <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            st      <= st_n;
            grid    <= grid_n;
            col     <= col_n;
            row     <= row_n;
            o_lines <= lines_n;
            o_over  <= over_n;
            drop_q  <= i_drop;
        end
    end

    assign pix_col = COL_W'(i_cx >> CELL_SH);
    assign pix_row = ROW_W'(i_cy >> CELL_SH);

    always_comb begin
        pix_r = COLOR_BG;
        pix_g = COLOR_BG;
        pix_b = COLOR_BG;
        if (i_in_win) begin
            if ((st == W_PLAY || st == W_FROZEN) && pix_col == col && pix_row == row) begin
                pix_r = FALL_R;
                pix_g = FALL_G;
                pix_b = FALL_B;
            end else if (grid[pix_row][pix_col]) begin
                pix_r = LOCK_R;
                pix_g = LOCK_G;
                pix_b = LOCK_B;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_r <= COLOR_BG;
            o_g <= COLOR_BG;
            o_b <= COLOR_BG;
        end else begin
            o_r <= pix_r;
            o_g <= pix_g;
            o_b <= pix_b;
        end
    end

    a_col_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        col < WELL_W);

    a_lines_mono: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (st == W_PLAY && !i_start) |=> (o_lines >= $past(o_lines)));

endmodule

// File: hw/title_screen.sv
`timescale 1ns/100ps

module title_screen
    import tetris_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [9:0] i_x,
    input  logic [9:0] i_y,
    input  logic       i_mode,
    output logic [7:0] o_r,
    output logic [7:0] o_g,
    output logic [7:0] o_b
);

    // inclusive bounds on both axes
    function automatic logic in_rect(input logic [9:0] x, input logic [9:0] y,
                                     input int x0, input int x1,
                                     input int y0, input int y1);
        return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
    endfunction

    // 5 pixel border around a box
    function automatic logic in_frame(input logic [9:0] x, input logic [9:0] y,
                                      input int x0, input int x1,
                                      input int y0, input int y1);
        return in_rect(x, y, x0, x1, y0, y1) &&
               !in_rect(x, y, x0 + 5, x1 - 5, y0 + 5, y1 - 5);
    endfunction

    // letter P with its top edge at y0
    function automatic logic p_glyph(input logic [9:0] x, input logic [9:0] y, input int y0);
        return in_rect(x, y, 330, 340, y0, y0 + 60) ||
               in_rect(x, y, 340, 360, y0, y0 + 10) ||
               in_rect(x, y, 350, 360, y0 + 10, y0 + 30) ||
               in_rect(x, y, 340, 350, y0 + 20, y0 + 30);
    endfunction

    logic hit_title;
    logic hit_label;
    logic hit_frame;

    assign hit_title = in_rect(i_x, i_y, 55, 135, 80, 100) ||
                       in_rect(i_x, i_y, 85, 105, 100, 180) ||
                       in_rect(i_x, i_y, 145, 165, 80, 180) ||
                       in_rect(i_x, i_y, 165, 225, 80, 100) ||
                       in_rect(i_x, i_y, 165, 225, 120, 140) ||
                       in_rect(i_x, i_y, 165, 225, 160, 180) ||
                       in_rect(i_x, i_y, 235, 315, 80, 100) ||
                       in_rect(i_x, i_y, 265, 285, 100, 180) ||
                       in_rect(i_x, i_y, 325, 345, 80, 180) ||
                       in_rect(i_x, i_y, 345, 385, 80, 100) ||
                       in_rect(i_x, i_y, 385, 405, 100, 120) ||
                       in_rect(i_x, i_y, 345, 385, 120, 140) ||
                       in_rect(i_x, i_y, 365, 385, 140, 160) ||
                       in_rect(i_x, i_y, 385, 405, 160, 180) ||
                       in_rect(i_x, i_y, 425, 485, 80, 100) ||
                       in_rect(i_x, i_y, 445, 465, 100, 160) ||
                       in_rect(i_x, i_y, 415, 495, 160, 180) ||
                       in_rect(i_x, i_y, 505, 585, 80, 100) ||
                       in_rect(i_x, i_y, 505, 525, 100, 140) ||
                       in_rect(i_x, i_y, 525, 585, 120, 140) ||
                       in_rect(i_x, i_y, 565, 585, 140, 160) ||
                       in_rect(i_x, i_y, 505, 585, 160, 180);

    // digits 1 and 2, then the two P glyphs
    assign hit_label = in_rect(i_x, i_y, 285, 290, 230, 240) ||
                       in_rect(i_x, i_y, 290, 300, 230, 280) ||
                       in_rect(i_x, i_y, 280, 310, 280, 290) ||
                       in_rect(i_x, i_y, 280, 310, 330, 340) ||
                       in_rect(i_x, i_y, 300, 310, 340, 360) ||
                       in_rect(i_x, i_y, 280, 310, 355, 365) ||
                       in_rect(i_x, i_y, 280, 290, 365, 390) ||
                       in_rect(i_x, i_y, 280, 310, 380, 390) ||
                       p_glyph(i_x, i_y, 230) ||
                       p_glyph(i_x, i_y, 330);

    assign hit_frame = i_mode ? in_frame(i_x, i_y, 255, 385, 320, 400)
                              : in_frame(i_x, i_y, 255, 385, 220, 300);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_r <= COLOR_BG;
            o_g <= COLOR_BG;
            o_b <= COLOR_BG;
        end else begin
            o_r <= (hit_title || hit_label || hit_frame) ? COLOR_TEXT : COLOR_BG;
            o_g <= (hit_title || hit_label || hit_frame) ? COLOR_TEXT : COLOR_BG;
            o_b <= (hit_title || hit_label || hit_frame) ? COLOR_TEXT : COLOR_BG;
        end
    end

endmodule

// File: sim/tb_tetris.sv
`timescale 1ns/100ps

module tb_tetris
    import tetris_pkg::*;
();

    // the tests need roughly 8000 cycles
    localparam int TIMEOUT = 20000;
    localparam int NRECT = 38;

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic [9:0]  i_x;
    logic [9:0]  i_y;
    logic [7:0]  i_key_1;
    logic        i_key_1_valid;
    logic [7:0]  i_key_2;
    logic        i_key_2_valid;
    logic        i_drop;
    menu_state_t o_menu_state;
    logic [7:0]  o_lines_1;
    logic [7:0]  o_lines_2;
    logic        o_over_1;
    logic        o_over_2;
    logic [7:0]  o_vga_r;
    logic [7:0]  o_vga_g;
    logic [7:0]  o_vga_b;

    // reference state
    menu_state_t       m_state;
    logic              m_mode;
    logic [WELL_W-1:0] g [2][WELL_H];
    int                cc [2];
    int                cr [2];
    int                ln [2];
    logic              ov [2];
    // 0 idle, 1 playing, 2 frozen, 3 over
    int                ws [2];

    logic        arm = 1'b0;
    logic        go = 1'b0;
    logic [23:0] exp_rgb, q_rgb;
    int          exp_x, exp_y, q_x, q_y;
    menu_state_t exp_st, q_st;
    logic [7:0]  exp_ln1, exp_ln2, q_ln1, q_ln2;
    logic        exp_ov1, exp_ov2, q_ov1, q_ov2;
    int          cycles = 0;
    int          n_checks = 0;
    int          test_errs = 0;
    int          total_errs = 0;
    int          n_tests = 0;
    int          n_bad = 0;
    string       cur_test;
    logic [31:0] rng;

    // title letters, digit labels and the two P glyphs as x0, x1, y0, y1 inclusive
    int rects [NRECT][4] = '{
        '{55, 135, 80, 100}, '{85, 105, 100, 180}, '{145, 165, 80, 180},
        '{165, 225, 80, 100}, '{165, 225, 120, 140}, '{165, 225, 160, 180},
        '{235, 315, 80, 100}, '{265, 285, 100, 180}, '{325, 345, 80, 180},
        '{345, 385, 80, 100}, '{385, 405, 100, 120}, '{345, 385, 120, 140},
        '{365, 385, 140, 160}, '{385, 405, 160, 180}, '{425, 485, 80, 100},
        '{445, 465, 100, 160}, '{415, 495, 160, 180}, '{505, 585, 80, 100},
        '{505, 525, 100, 140}, '{525, 585, 120, 140}, '{565, 585, 140, 160},
        '{505, 585, 160, 180}, '{285, 290, 230, 240}, '{290, 300, 230, 280},
        '{280, 310, 280, 290}, '{280, 310, 330, 340}, '{300, 310, 340, 360},
        '{280, 310, 355, 365}, '{280, 290, 365, 390}, '{280, 310, 380, 390},
        '{330, 340, 230, 290}, '{340, 360, 230, 240}, '{350, 360, 240, 260},
        '{340, 350, 250, 260}, '{330, 340, 330, 390}, '{340, 360, 330, 340},
        '{350, 360, 340, 360}, '{340, 350, 350, 360}
    };

    tetris_top dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_x(i_x), .i_y(i_y),
        .i_key_1(i_key_1), .i_key_1_valid(i_key_1_valid),
        .i_key_2(i_key_2), .i_key_2_valid(i_key_2_valid), .i_drop(i_drop),
        .o_menu_state(o_menu_state), .o_lines_1(o_lines_1), .o_lines_2(o_lines_2),
        .o_over_1(o_over_1), .o_over_2(o_over_2),
        .o_vga_r(o_vga_r), .o_vga_g(o_vga_g), .o_vga_b(o_vga_b)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic logic title_hit(input int x, input int y);
        logic hit;
        int   y0;
        hit = 1'b0;
        for (int i = 0; i < NRECT; i++) begin
            if (x >= rects[i][0] && x <= rects[i][1] && y >= rects[i][2] && y <= rects[i][3])
                hit = 1'b1;
        end
        // 5 pixel frame around the chosen label
        y0 = m_mode ? 320 : 220;
        if (x >= 255 && x <= 385 && y >= y0 && y <= y0 + 80 &&
            !(x >= 260 && x <= 380 && y >= y0 + 5 && y <= y0 + 75))
            hit = 1'b1;
        return hit;
    endfunction

    function automatic int win_x(input int p);
        if (p == 1)
            return WIN_2P_X_B;
        return (m_state == MENU_2P) ? WIN_2P_X_A : WIN_1P_X;
    endfunction

    function automatic logic [23:0] ref_pixel(input int x, input int y);
        int c;
        int r;
        if (m_state == MENU_IDLE)
            return title_hit(x, y) ? {3{COLOR_TEXT}} : {3{COLOR_BG}};
        for (int p = 0; p < 2; p++) begin
            if ((p == 0 || m_state == MENU_2P) && x >= win_x(p) && x < win_x(p) + WIN_W &&
                y >= WIN_Y && y < WIN_Y + WIN_H) begin
                c = (x - win_x(p)) / CELL_PX;
                r = (y - WIN_Y) / CELL_PX;
                // a well that is over shows no falling cell
                if ((ws[p] == 1 || ws[p] == 2) && c == cc[p] && r == cr[p])
                    return {FALL_R, FALL_G, FALL_B};
                if (g[p][r][c])
                    return {LOCK_R, LOCK_G, LOCK_B};
            end
        end
        return {3{COLOR_BG}};
    endfunction

    task automatic start_wells();
        for (int p = 0; p < 2; p++) begin
            if (p == 0 || m_state == MENU_2P) begin
                for (int r = 0; r < WELL_H; r++)
                    g[p][r] = '0;
                cc[p] = 4;
                cr[p] = 0;
                ln[p] = 0;
                ov[p] = 1'b0;
                ws[p] = 1;
            end
        end
    endtask

    task automatic stop_wells();
        for (int p = 0; p < 2; p++) begin
            if (ws[p] == 1)
                ws[p] = 2;
        end
    endtask

    task automatic apply_key(input int p, input logic [7:0] code);
        if (ws[p] == 1 && code == KEY_LEFT && cc[p] > 0 && !g[p][cr[p]][cc[p] - 1])
            cc[p]--;
        else if (ws[p] == 1 && code == KEY_RIGHT && cc[p] < WELL_W - 1 &&
                 !g[p][cr[p]][cc[p] + 1])
            cc[p]++;
        if (p == 0 && m_state == MENU_IDLE) begin
            if (code == KEY_UP)
                m_mode = 1'b0;
            else if (code == KEY_DOWN)
                m_mode = 1'b1;
            else if (code == KEY_ENTER) begin
                m_state = m_mode ? MENU_2P : MENU_1P;
                start_wells();
            end
        end else if (p == 0 && code == KEY_ESC) begin
            m_state = MENU_IDLE;
            stop_wells();
        end
    endtask

    task automatic apply_drop();
        logic rose;
        rose = 1'b0;
        for (int p = 0; p < 2; p++) begin
            if (ws[p] == 1) begin
                if (cr[p] == WELL_H - 1 || g[p][cr[p] + 1][cc[p]]) begin
                    g[p][cr[p]][cc[p]] = 1'b1;
                    if (&g[p][cr[p]]) begin
                        for (int r = cr[p]; r > 0; r--)
                            g[p][r] = g[p][r - 1];
                        g[p][0] = '0;
                        ln[p]++;
                    end
                    cc[p] = 4;
                    cr[p] = 0;
                    if (g[p][0][4]) begin
                        ov[p] = 1'b1;
                        ws[p] = 3;
                        rose = 1'b1;
                    end
                end else begin
                    cr[p]++;
                end
            end
        end
        // first game over ends a two-player round
        if (rose && m_state == MENU_2P)
            stop_wells();
    endtask

    task automatic mismatch(input string what, input int unsigned e, input int unsigned a);
        $display("error %s: %s expected %0h actual %0h", cur_test, what, e, a);
        test_errs++;
    endtask

    // compare one cycle after the probe position was applied
    always @(posedge i_clk) begin
        go <= arm;
        q_rgb <= exp_rgb;
        q_x <= exp_x;
        q_y <= exp_y;
        q_st <= exp_st;
        q_ln1 <= exp_ln1;
        q_ln2 <= exp_ln2;
        q_ov1 <= exp_ov1;
        q_ov2 <= exp_ov2;
    end

    always @(negedge i_clk) begin
        if (go) begin
            n_checks++;
            assert ({o_vga_r, o_vga_g, o_vga_b} == q_rgb) else
                mismatch($sformatf("pixel at %0d,%0d", q_x, q_y), q_rgb,
                         {o_vga_r, o_vga_g, o_vga_b});
            assert (o_menu_state == q_st) else mismatch("menu state", q_st, o_menu_state);
            assert (o_lines_1 == q_ln1) else mismatch("lines of player one", q_ln1, o_lines_1);
            assert (o_lines_2 == q_ln2) else mismatch("lines of player two", q_ln2, o_lines_2);
            assert (o_over_1 == q_ov1) else mismatch("over of player one", q_ov1, o_over_1);
            assert (o_over_2 == q_ov2) else mismatch("over of player two", q_ov2, o_over_2);
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    task automatic roll(input int n, output int r);
        rng = xorshift(rng);
        r = int'(rng % n);
    endtask

    task automatic probe(input int x, input int y);
        i_x = 10'(x);
        i_y = 10'(y);
        exp_x = x;
        exp_y = y;
        exp_rgb = ref_pixel(x, y);
        exp_st = m_state;
        exp_ln1 = 8'(ln[0]);
        exp_ln2 = 8'(ln[1]);
        exp_ov1 = ov[0];
        exp_ov2 = ov[1];
        arm = 1'b1;
        @(negedge i_clk);
        arm = 1'b0;
    endtask

    task automatic probe_cell(input int p, input int c, input int r);
        probe(win_x(p) + c * CELL_PX + 8, WIN_Y + r * CELL_PX + 8);
    endtask

    task automatic probe_falling(input int p);
        probe_cell(p, cc[p], cr[p]);
    endtask

    task automatic probe_grid(input int p);
        for (int r = 0; r < WELL_H; r++) begin
            for (int c = 0; c < WELL_W; c++)
                probe_cell(p, c, r);
        end
    endtask

    task automatic press(input int p, input logic [7:0] code);
        if (p == 0) begin
            i_key_1 = code;
            i_key_1_valid = 1'b1;
        end else begin
            i_key_2 = code;
            i_key_2_valid = 1'b1;
        end
        apply_key(p, code);
        @(negedge i_clk);
        i_key_1_valid = 1'b0;
        i_key_2_valid = 1'b0;
        idle(4);
    endtask

    // four idle cycles cover the stop that follows a game over
    task automatic drop();
        i_drop = 1'b1;
        apply_drop();
        @(negedge i_clk);
        i_drop = 1'b0;
        idle(4);
    endtask

    task automatic drop_until_lock(input int p);
        drop();
        while (cr[p] != 0 && ws[p] == 1)
            drop();
        probe_falling(p);
    endtask

    task automatic walk(input int p, input int t);
        for (int i = 0; i < WELL_W && cc[p] != t; i++)
            press(p, (cc[p] < t) ? KEY_RIGHT : KEY_LEFT);
        probe_falling(p);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        idle(2);
        n_tests++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: passed", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, test_errs);
            n_bad++;
        end
    endtask

    initial begin
        int x;
        int y;
        int c;
        int n;
        i_rst_n = 1'b0;
        i_x = '0;
        i_y = '0;
        i_key_1 = '0;
        i_key_1_valid = 1'b0;
        i_key_2 = '0;
        i_key_2_valid = 1'b0;
        i_drop = 1'b0;
        rng = 32'd7241;
        m_state = MENU_IDLE;
        m_mode = 1'b0;
        for (int p = 0; p < 2; p++) begin
            for (int r = 0; r < WELL_H; r++)
                g[p][r] = '0;
            cc[p] = 4;
            cr[p] = 0;
            ln[p] = 0;
            ov[p] = 1'b0;
            ws[p] = 0;
        end
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        idle(1);

        begin_test("menu");
        probe(0, 0);
        press(0, KEY_DOWN);
        press(0, KEY_ENTER);
        probe(320, 240);
        press(0, KEY_ESC);
        probe(0, 0);
        press(0, KEY_UP);
        press(0, KEY_ENTER);
        probe(320, 240);
        press(0, KEY_ESC);
        probe(0, 0);
        end_test();

        begin_test("title page");
        for (int i = 0; i < 600; i++) begin
            if (i == 300)
                press(0, KEY_DOWN);
            roll(640, x);
            roll(480, y);
            // every other sample lands near the labels and frames
            if ((i % 2) == 1) begin
                roll(160, x);
                roll(200, y);
                x += 250;
                y += 210;
            end
            probe(x, y);
        end
        press(0, KEY_UP);
        end_test();

        begin_test("stacking to game over");
        press(0, KEY_ENTER);
        n = 0;
        while (!o_over_1 && n < 300) begin
            drop();
            n++;
            probe_falling(0);
        end
        // 20 + 19 + ... + 1 drops fill column 4
        assert (n == 210) else mismatch("drops until game over", 210, n);
        probe_grid(0);
        end_test();

        begin_test("restart");
        press(0, KEY_ESC);
        probe(0, 0);
        press(0, KEY_ENTER);
        probe_grid(0);
        end_test();

        begin_test("row clears");
        roll(WELL_W, c);
        walk(0, c);
        drop_until_lock(0);
        walk(0, c);
        drop_until_lock(0);
        for (int k = 0; k < 2 * (WELL_W - 1); k++) begin
            do
                roll(WELL_W, c);
            while (g[0][WELL_H - 1][c]);
            walk(0, c);
            drop_until_lock(0);
            if (k == WELL_W - 2)
                probe_grid(0);
        end
        assert (o_lines_1 == 8'd2) else mismatch("rows cleared", 2, o_lines_1);
        probe_grid(0);
        end_test();

        begin_test("two-player windows");
        press(0, KEY_ESC);
        press(0, KEY_DOWN);
        press(0, KEY_ENTER);
        probe_falling(0);
        probe_falling(1);
        probe(40, 200);
        probe(320, 200);
        probe(600, 420);
        press(0, KEY_LEFT);
        press(1, KEY_RIGHT);
        press(1, KEY_RIGHT);
        probe_falling(0);
        probe_falling(1);
        probe_cell(0, 4, 0);
        probe_cell(1, 4, 0);
        // player two spreads its cells so player one tops out first
        n = 0;
        c = 0;
        while (!ov[0] && n < 400) begin
            if (ws[1] == 1 && cr[1] == 0 && cc[1] == 4) begin
                walk(1, c % WELL_W);
                c++;
            end
            drop();
            n++;
        end
        assert (o_over_1 && !o_over_2) else begin
            $display("%s: player one did not reach game over before player two", cur_test);
            test_errs++;
        end
        probe_falling(1);
        repeat (3) drop();
        probe_falling(1);
        probe_grid(0);
        probe_grid(1);
        end_test();

        idle(2);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_bad, n_checks, total_errs);
        if (total_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
